/* piano_consts.svh */
`ifndef PIANO_CONSTS_SVH
`define PIANO_CONSTS_SVH

`define PIANO_NUM_VOICES 3
`define PIANO_AMP_W 8
`define PIANO_FRAME_BITS 32

// frame that arms the note receiver
`define PIANO_SYNC_WORD 32'h0000FFFF

// envelope pacing
`define PIANO_ENV_TICK 2      // clk cycles per gain step
`define PIANO_HOLD_TICKS 128  // steps held at full gain

// serial DAC timing, in clk cycles unless noted
`define PIANO_DAC_HALF 4
`define PIANO_DAC_LEAD_BITS 4 // zero bits ahead of the sample
`define PIANO_DAC_STROBE 4

`endif

/* piano_pkg.sv */
`default_nettype none
`include "piano_consts.svh"

package piano_pkg;

    typedef logic [`PIANO_AMP_W-1:0] amp_t;

    // 255 means full scale
    typedef logic [7:0] gain_t;

    typedef logic [1:0] note_count_t;

    typedef amp_t [`PIANO_NUM_VOICES-1:0] amp_arr_t; // one byte per voice

    typedef enum logic [2:0] {
        ENV_IDLE,
        ENV_ATTACK,
        ENV_HOLD,
        ENV_DECAY,
        ENV_DONE
    } env_state_t;

endpackage

`default_nettype wire

/* note_bus_if.sv */
`timescale 1ns/1ns
`default_nettype none

// latched note frame, stable between frames
interface note_bus_if;

    piano_pkg::amp_arr_t    amp;
    piano_pkg::note_count_t count;
    logic                   frame_valid;   // high from the first frame on

    modport src (
        output amp,
        output count,
        output frame_valid
    );

    modport voice (
        input amp,
        input frame_valid
    );

    modport mix (
        input count
    );

endinterface

`default_nettype wire

/* spi_note_rx.sv */
`timescale 1ns/1ns
`default_nettype none
`include "piano_consts.svh"

module spi_note_rx (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    sck,
    input  logic    sdi,
    note_bus_if.src bus
);

    localparam int CNT_W = $clog2(`PIANO_FRAME_BITS);
    localparam int AMP_W = `PIANO_AMP_W;
    localparam int CNT_LSB = `PIANO_NUM_VOICES * AMP_W;

    logic [1:0]                   sck_sync;
    logic [1:0]                   sdi_sync;
    logic                         sck_last;
    logic                         bit_take;
    logic [`PIANO_FRAME_BITS-1:0] shift_q;
    logic [`PIANO_FRAME_BITS-1:0] shift_next;
    logic                         armed;
    logic [CNT_W-1:0]             bit_cnt;
    logic                         latch_pend;
    piano_pkg::amp_arr_t          amp_q;
    piano_pkg::note_count_t       count_q;
    logic                         valid_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sck_sync <= '0;
            sdi_sync <= '0;
            sck_last <= 1'b0;
        end
        else
        begin
            sck_sync <= {sck_sync[0], sck};
            sdi_sync <= {sdi_sync[0], sdi};
            sck_last <= sck_sync[1];
        end
    end

    assign bit_take   = sck_sync[1] & ~sck_last;   // synced sck rising
    assign shift_next = {shift_q[`PIANO_FRAME_BITS-2:0], sdi_sync[1]};

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            shift_q    <= '1;     // all ones, so stray zeros can't fake a sync
            armed      <= 1'b0;
            bit_cnt    <= '0;
            latch_pend <= 1'b0;
        end
        else
        begin
            latch_pend <= 1'b0;
            if (bit_take)
            begin
                shift_q <= shift_next;
                bit_cnt <= bit_cnt + 1'b1;
                if (!armed)
                begin
                    if (shift_next == `PIANO_SYNC_WORD)
                    begin
                        armed   <= 1'b1;
                        bit_cnt <= '0;
                    end
                end
                else if (bit_cnt == CNT_W'(`PIANO_FRAME_BITS - 1))
                    latch_pend <= 1'b1;    // full frame in, latch next edge
            end
        end
    end

    // frame register steering the voices and the mixer
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            amp_q   <= '0;
            count_q <= '0;
            valid_q <= 1'b0;
        end
        else if (latch_pend)
        begin
            for (int v = 0; v < `PIANO_NUM_VOICES; v++)
                amp_q[v] <= shift_q[v*AMP_W +: AMP_W];
            count_q <= shift_q[CNT_LSB +: $bits(piano_pkg::note_count_t)];
            valid_q <= 1'b1;
        end
    end

    assign bus.amp         = amp_q;
    assign bus.count       = count_q;
    assign bus.frame_valid = valid_q;

endmodule

`default_nettype wire

/* key_envelope.sv */
`timescale 1ns/1ns
`default_nettype none
`include "piano_consts.svh"

module key_envelope #(
    parameter int VOICE = 0
) (
    input  logic            clk,
    input  logic            rst_n,
    note_bus_if.voice       bus,
    output piano_pkg::amp_t level,
    output logic            active,
    output logic            done
);

    localparam int AMP_W  = `PIANO_AMP_W;
    localparam int TICK_W = $clog2(`PIANO_ENV_TICK + 1);
    localparam int HOLD_W = $clog2(`PIANO_HOLD_TICKS + 1);

    piano_pkg::env_state_t state;
    piano_pkg::gain_t      gain;
    piano_pkg::amp_t       amp;
    logic                  live;
    logic                  step;
    logic [TICK_W-1:0]     tick;
    logic [HOLD_W-1:0]     hold_cnt;
    logic [2*AMP_W-1:0]    product;

    assign amp     = bus.amp[VOICE];
    assign live    = bus.frame_valid && (amp != '0);   // key is down
    assign step    = (tick == TICK_W'(`PIANO_ENV_TICK - 1));
    assign product = amp * gain;

    always_ff @(posedge clk)
    begin
        if (!rst_n || !live)
        begin
            state    <= piano_pkg::ENV_IDLE;
            gain     <= '0;
            tick     <= '0;
            hold_cnt <= '0;
        end
        else
        begin
            tick <= step ? '0 : tick + 1'b1;
            case (state)
                piano_pkg::ENV_IDLE:
                begin
                    state <= piano_pkg::ENV_ATTACK;
                    tick  <= '0;
                end
                piano_pkg::ENV_ATTACK:
                    if (step)
                    begin
                        gain <= gain + 1'b1;
                        if (gain == 8'd254)
                        begin
                            state    <= piano_pkg::ENV_HOLD;
                            hold_cnt <= '0;
                        end
                    end
                piano_pkg::ENV_HOLD:
                    if (step)
                    begin
                        if (hold_cnt == HOLD_W'(`PIANO_HOLD_TICKS - 1))
                            state <= piano_pkg::ENV_DECAY;
                        else
                            hold_cnt <= hold_cnt + 1'b1;
                    end
                piano_pkg::ENV_DECAY:
                    if (step)
                    begin
                        gain <= gain - 1'b1;
                        if (gain == 8'd1)
                            state <= piano_pkg::ENV_DONE;
                    end
                piano_pkg::ENV_DONE:
                    tick <= '0;             // wait here for the key to lift
                default:
                    state <= piano_pkg::ENV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            level <= '0;
        else
        begin
            case (state)
                piano_pkg::ENV_HOLD:
                    level <= amp;           // exact peak
                piano_pkg::ENV_ATTACK, piano_pkg::ENV_DECAY:
                    level <= product[2*AMP_W-1:AMP_W];
                default:
                    level <= '0;
            endcase
        end
    end

    assign active = (state == piano_pkg::ENV_ATTACK) ||
                    (state == piano_pkg::ENV_HOLD) ||
                    (state == piano_pkg::ENV_DECAY);
    assign done   = (state == piano_pkg::ENV_DONE);

endmodule

`default_nettype wire

/* voice_mixer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "piano_consts.svh"

module voice_mixer (
    input  logic            clk,
    input  logic            rst_n,
    note_bus_if.mix         bus,
    input  piano_pkg::amp_t level0,
    input  piano_pkg::amp_t level1,
    input  piano_pkg::amp_t level2,
    output piano_pkg::amp_t mix
);

    localparam int SUM_W = `PIANO_AMP_W + 2;

    logic [SUM_W-1:0] sum;
    logic [SUM_W-1:0] third;
    logic [SUM_W-1:0] mix_next;

    assign sum = SUM_W'(level0) + SUM_W'(level1) + SUM_W'(level2);

    // shift-sum approximation of sum/3
    assign third = (sum >> 2) + (sum >> 4) + (sum >> 6) + (sum >> 8);

    always_comb
    begin
        case (bus.count)
            2'd0:    mix_next = '0;
            2'd1:    mix_next = sum;
            2'd2:    mix_next = sum >> 1;
            default: mix_next = third;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            mix <= '0;
        else
            mix <= mix_next[`PIANO_AMP_W-1:0];   // truncated, no clamp
    end

endmodule

`default_nettype wire

/* dac_serializer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "piano_consts.svh"

module dac_serializer (
    input  logic            clk,
    input  logic            rst_n,
    input  piano_pkg::amp_t sample,
    output logic            dclk,
    output logic            data,
    output logic            load,
    output logic            ldac
);

    localparam int BIT_CYC = 2 * `PIANO_DAC_HALF;
    localparam int NBITS   = `PIANO_DAC_LEAD_BITS + `PIANO_AMP_W;
    localparam int LOAD_AT = NBITS * BIT_CYC;               // end of the bit phase
    localparam int LDAC_AT = LOAD_AT + `PIANO_DAC_STROBE;
    localparam int IDLE_AT = LDAC_AT + `PIANO_DAC_STROBE;   // last cycle of a frame
    localparam int CNT_W   = $clog2(IDLE_AT + 1);
    localparam int PH_W    = $clog2(BIT_CYC);

    logic [CNT_W-1:0] cnt;
    logic [PH_W-1:0]  ph;
    logic [NBITS-1:0] shift_q;
    logic             in_bits;

    assign in_bits = (cnt < CNT_W'(LOAD_AT));

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cnt <= '0;
            ph  <= '0;
        end
        else if (cnt == CNT_W'(IDLE_AT))
        begin
            cnt <= '0;
            ph  <= '0;
        end
        else
        begin
            cnt <= cnt + 1'b1;
            ph  <= (ph == PH_W'(BIT_CYC - 1)) ? '0 : ph + 1'b1;
        end
    end

    // lead zeros go out first, then the sample MSB first
    always_ff @(posedge clk)
    begin
        if (cnt == '0)
            shift_q <= {{`PIANO_DAC_LEAD_BITS{1'b0}}, sample};
        else if (in_bits && ph == PH_W'(1))
            shift_q <= shift_q << 1;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            dclk <= 1'b0;
            data <= 1'b0;
            load <= 1'b1;
            ldac <= 1'b1;
        end
        else if (in_bits)
        begin
            load <= 1'b1;
            ldac <= 1'b1;
            dclk <= (ph < PH_W'(`PIANO_DAC_HALF));   // high in first half
            if (ph == PH_W'(1))
                data <= shift_q[NBITS-1];          // change mid high phase
        end
        else
        begin
            dclk <= 1'b0;
            load <= (cnt >= CNT_W'(LDAC_AT));
            ldac <= (cnt < CNT_W'(LDAC_AT)) || (cnt == CNT_W'(IDLE_AT));
        end
    end

endmodule

`default_nettype wire

/* piano_top.sv */
`timescale 1ns/1ns
`default_nettype none

module piano_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sck,
    input  logic       sdi,
    output logic [5:0] led,      // active/done pairs, voice 0 at the top
    output logic       dclk,
    output logic       data,
    output logic       load,
    output logic       ldac
);

    piano_pkg::amp_t level0;
    piano_pkg::amp_t level1;
    piano_pkg::amp_t level2;
    piano_pkg::amp_t mix;

    note_bus_if bus ();

    spi_note_rx u_rx (
        .clk   (clk),
        .rst_n (rst_n),
        .sck   (sck),
        .sdi   (sdi),
        .bus   (bus)
    );

    key_envelope #(.VOICE(0)) u_voice0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus    (bus),
        .level  (level0),
        .active (led[5]),
        .done   (led[4])
    );

    key_envelope #(.VOICE(1)) u_voice1 (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus    (bus),
        .level  (level1),
        .active (led[3]),
        .done   (led[2])
    );

    key_envelope #(.VOICE(2)) u_voice2 (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus    (bus),
        .level  (level2),
        .active (led[1]),
        .done   (led[0])
    );

    voice_mixer u_mixer (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus    (bus),
        .level0 (level0),
        .level1 (level1),
        .level2 (level2),
        .mix    (mix)
    );

    dac_serializer u_dac (
        .clk    (clk),
        .rst_n  (rst_n),
        .sample (mix),
        .dclk   (dclk),
        .data   (data),
        .load   (load),
        .ldac   (ldac)
    );

endmodule

`default_nettype wire

/* piano_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module piano_assert (
    input logic       clk,
    input logic       rst_n,
    input logic [5:0] led,
    input logic       dclk,
    input logic       load,
    input logic       ldac
);

    // the DAC takes the word on load, then updates its output on ldac
    a_strobes_apart: assert property (@(posedge clk) disable iff (!rst_n) load || ldac)
        else $error("load and ldac low in the same cycle");

    a_dclk_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (!load || !ldac) |-> !dclk)
        else $error("dclk high during a DAC strobe");

    a_led_reset: assert property (@(posedge clk) $rose(rst_n) |-> led == '0)
        else $error("led not clear right after reset");

endmodule

bind piano_top piano_assert u_assert (
    .clk   (clk),
    .rst_n (rst_n),
    .led   (led),
    .dclk  (dclk),
    .load  (load),
    .ldac  (ldac)
);

`default_nettype wire

/* piano_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "piano_consts.svh"

module piano_tb;

    localparam int LEAD       = `PIANO_DAC_LEAD_BITS;
    localparam int NBITS      = LEAD + `PIANO_AMP_W;
    localparam int FRAME_CYC  = NBITS * 2 * `PIANO_DAC_HALF + 2 * `PIANO_DAC_STROBE + 1;
    localparam int SCK_HALF   = 8;                                  // clk cycles per sck phase
    localparam int WORD_CYC   = `PIANO_FRAME_BITS * 2 * SCK_HALF + SCK_HALF;
    localparam int ENV_CYC    = `PIANO_ENV_TICK * (2 * 255 + `PIANO_HOLD_TICKS) + 8;
    localparam int ENV_FRAMES = ENV_CYC / FRAME_CYC + 3;
    localparam int PLAY_CYC   = 2 * WORD_CYC + (ENV_FRAMES + 2) * FRAME_CYC;
    localparam int RUN_CYC    = 4 * PLAY_CYC + 6 * WORD_CYC + 10 * FRAME_CYC;

    logic       clk;
    logic       rst_n;
    logic       sck;
    logic       sdi;
    logic [5:0] led;
    logic       dclk;
    logic       data;
    logic       load;
    logic       ldac;
    integer     seed;
    int         errors;
    int         tests;
    int         failed;
    int         test_errors;
    string      cur_test;

    piano_top dut0 (
        .clk   (clk),
        .rst_n (rst_n),
        .sck   (sck),
        .sdi   (sdi),
        .led   (led),
        .dclk  (dclk),
        .data  (data),
        .load  (load),
        .ldac  (ldac)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial
    begin
        #(2 * RUN_CYC * 8);
        $display("timeout: run exceeded %0d clk cycles", 2 * RUN_CYC);
        $display("Test failed");
        $finish;
    end

    task automatic check_amp(input string name, input piano_pkg::amp_t exp_val,
                             input piano_pkg::amp_t act_val);
        if (exp_val !== act_val)
        begin
            errors++;
            $display("error: %s expected 0x%02h actual 0x%02h", name, exp_val, act_val);
        end
    endtask

    task automatic check_led(input string name, input logic [5:0] exp_val,
                             input logic [5:0] act_val);
        if (exp_val !== act_val)
        begin
            errors++;
            $display("error: %s led expected %06b actual %06b", name, exp_val, act_val);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("%s: %s", cur_test, msg);
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = errors;
        tests++;
    endtask

    task automatic end_test();
        if (errors != test_errors)
        begin
            failed++;
            $display("test %-12s FAIL", cur_test);
        end
        else
            $display("test %-12s ok", cur_test);
    endtask

    // one serial word, MSB first, sdi settled well before each sck rise
    task automatic send_word(input logic [`PIANO_FRAME_BITS-1:0] word);
        for (int i = `PIANO_FRAME_BITS - 1; i >= 0; i--)
        begin
            sdi = word[i];
            repeat (SCK_HALF) @(negedge clk);
            sck = 1'b1;
            repeat (SCK_HALF) @(negedge clk);
            sck = 1'b0;
        end
        repeat (SCK_HALF) @(negedge clk);
    endtask

    task automatic await_ldac(input logic level);
        int guard;
        guard = 0;
        while (ldac !== level && guard < 3 * FRAME_CYC)
        begin
            @(negedge clk);
            guard++;
        end
        if (ldac !== level)
            note_failure("ldac strobe never arrived");
    endtask

    // starts after the next ldac pulse; returns with ldac of this frame low
    task automatic capture_frame(output piano_pkg::amp_t sample);
        logic [NBITS-1:0] bits;
        logic             dclk_q;
        int               nbits;
        int               guard;
        bits  = '0;
        nbits = 0;
        guard = 0;
        await_ldac(1'b0);
        await_ldac(1'b1);
        dclk_q = dclk;
        while (load === 1'b1 && guard < 3 * FRAME_CYC)
        begin
            @(negedge clk);
            guard++;
            if (dclk_q === 1'b1 && dclk === 1'b0)
            begin
                bits = {bits[NBITS-2:0], data};
                nbits++;
            end
            dclk_q = dclk;
        end
        if (nbits != NBITS || bits[NBITS-1 -: LEAD] != '0)
        begin
            errors++;
            $display("error: %s DAC frame expected %0d bits, %0d lead zeros, actual %0d bits 0x%03h",
                     cur_test, NBITS, LEAD, nbits, bits);
        end
        guard = 0;
        while (ldac === 1'b1 && dclk === 1'b0 && guard < FRAME_CYC)
        begin
            @(negedge clk);
            guard++;
        end
        if (ldac !== 1'b0)
            note_failure("no ldac pulse between load and the next dclk");
        sample = bits[`PIANO_AMP_W-1:0];
    endtask

    // runs one chord through attack, hold and decay, then lifts the keys
    task automatic play_chord(input string name, input piano_pkg::amp_arr_t amps,
                              input piano_pkg::note_count_t count,
                              input piano_pkg::amp_t peak);
        piano_pkg::amp_t sample;
        piano_pkg::amp_t top;
        logic [5:0]      done_mask;
        int              hits;
        top       = '0;
        hits      = 0;
        done_mask = '0;
        begin_test(name);
        for (int v = 0; v < `PIANO_NUM_VOICES; v++)
            if (amps[v] != '0)
                done_mask[4 - 2 * v] = 1'b1;
        send_word({6'd0, count, amps});
        for (int f = 0; f < ENV_FRAMES; f++)
        begin
            capture_frame(sample);
            if (sample > top)
                top = sample;
            if (sample == peak)
                hits++;
        end
        check_amp(name, peak, top);
        if (peak != '0 && hits < 2)
            note_failure($sformatf("peak seen in %0d DAC frames, hold should give 2 or more",
                                   hits));
        check_amp(name, '0, sample);        // envelope has died away
        check_led(name, done_mask, led);
        send_word('0);
        check_led(name, '0, led);
        end_test();
    endtask

    task automatic test_reset();
        piano_pkg::amp_t sample;
        begin_test("reset");
        check_led("reset", '0, led);
        if (load !== 1'b1 || ldac !== 1'b1)
            note_failure("load or ldac not high after reset");
        repeat (2)
        begin
            capture_frame(sample);
            check_amp("reset", '0, sample);
        end
        end_test();
    endtask

    task automatic test_sync_gating();
        piano_pkg::amp_t sample;
        logic [31:0]     word;
        word = {6'd0, 2'd1, 16'd0, 8'h5a};   // voice 0 only
        begin_test("sync_gating");
        send_word(word);
        check_led("sync_gating", '0, led);
        capture_frame(sample);
        check_amp("sync_gating", '0, sample);
        send_word(`PIANO_SYNC_WORD);
        send_word(word);
        check_led("sync_gating", 6'b100000, led);
        send_word('0);
        check_led("sync_gating", '0, led);
        end_test();
    endtask

    task automatic test_mix_by_count();
        piano_pkg::amp_arr_t amps;
        logic [9:0]          s;
        for (int v = 0; v < `PIANO_NUM_VOICES; v++)
            amps[v] = piano_pkg::amp_t'(($random(seed) & 32'h7f) + 1);
        s = 10'(amps[0]) + 10'(amps[1]) + 10'(amps[2]);
        play_chord("mix_count2", amps, 2'd2, piano_pkg::amp_t'(s >> 1));
        play_chord("mix_count3", amps, 2'd3,
                   piano_pkg::amp_t'((s >> 2) + (s >> 4) + (s >> 6) + (s >> 8)));
        play_chord("mix_count0", amps, 2'd0, '0);
    endtask

    task automatic test_frame_format();
        piano_pkg::amp_t sample;
        begin_test("frame_format");
        send_word({6'd0, 2'd1, 16'd0, 8'hff});   // full scale keeps data bits busy
        repeat (4)
            capture_frame(sample);
        send_word('0);
        check_led("frame_format", '0, led);
        end_test();
    endtask

    initial
    begin
        piano_pkg::amp_arr_t amps;
        seed   = 32'h177287df;
        errors = 0;
        tests  = 0;
        failed = 0;
        rst_n  = 1'b0;
        sck    = 1'b0;
        sdi    = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_sync_gating();
        amps    = '0;
        amps[1] = piano_pkg::amp_t'($random(seed)) | 8'h01;
        play_chord("single_peak", amps, 2'd1, amps[1]);
        test_mix_by_count();
        test_frame_format();
        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
piano_pkg.sv
note_bus_if.sv
spi_note_rx.sv
key_envelope.sv
voice_mixer.sv
dac_serializer.sv
piano_top.sv
piano_assert.sv
piano_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the piano mixer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Test failed"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module piano_tb \
    -Mdir obj_dir -o piano_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/piano_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
    exit 1
fi
exit 0
